//--- common/mon_event_pkg.sv
//****************************************
// link monitor events
// fifo event struct and select codes
//****************************************

package mon_event_pkg;

   // width of one select field in the config register
   localparam int SEL_W = 4;

   // strobes and wait levels from the six link fifos
   // first field is the msb
   typedef struct packed {
      logic rx_rd_access;
      logic rx_rd_wait;
      logic rx_wr_access;
      logic rx_wr_wait;
      logic rx_wb_access;
      logic rx_wb_wait;
      logic tx_rd_access;
      logic tx_rd_wait;
      logic tx_wr_access;
      logic tx_wr_wait;
      logic tx_wb_access;
      logic tx_wb_wait;
   } mon_events_t;

   // per-counter event select
   // codes 2..13 follow the struct field order
   typedef enum logic [SEL_W-1:0] {
      SEL_OFF          = 4'd0,
      SEL_CLOCK        = 4'd1,
      SEL_RX_RD_ACCESS = 4'd2,
      SEL_RX_RD_WAIT   = 4'd3,
      SEL_RX_WR_ACCESS = 4'd4,
      SEL_RX_WR_WAIT   = 4'd5,
      SEL_RX_WB_ACCESS = 4'd6,
      SEL_RX_WB_WAIT   = 4'd7,
      SEL_TX_RD_ACCESS = 4'd8,
      SEL_TX_RD_WAIT   = 4'd9,
      SEL_TX_WR_ACCESS = 4'd10,
      SEL_TX_WR_WAIT   = 4'd11,
      SEL_TX_WB_ACCESS = 4'd12,
      SEL_TX_WB_WAIT   = 4'd13,
      SEL_OFF_14       = 4'd14,
      SEL_OFF_15       = 4'd15
   } mon_sel_e;

endpackage

//--- common/mon_reg_pkg.sv
//****************************************
// link monitor register map
// address enum and bus request struct
//****************************************

package mon_reg_pkg;

   // register address width on the simple memory port
   localparam int ADDR_W = 6;

   // counter addresses present in the map
   localparam int NUM_MON_MAX = 6;

   // register addresses
   typedef enum logic [ADDR_W-1:0] {
      MON_CFG = 6'h07,
      RX_MON0 = 6'h08,
      RX_MON1 = 6'h09,
      RX_MON2 = 6'h0A,
      TX_MON0 = 6'h0B,
      TX_MON1 = 6'h0C,
      TX_MON2 = 6'h0D
   } mon_addr_e;

   // counter i sits at MON_ADDR[i]
   // rx counters first, then tx
   localparam mon_addr_e MON_ADDR [NUM_MON_MAX] = '{
      RX_MON0,
      RX_MON1,
      RX_MON2,
      TX_MON0,
      TX_MON1,
      TX_MON2
   };

   // request strobes and address, 8 bits in all
   // write data is DW wide and travels beside it
   typedef struct packed {
      logic              access;
      logic              write;
      logic [ADDR_W-1:0] addr;
   } mi_req_t;

endpackage

//--- emon/mon_counter.sv
//****************************************
// link monitor counter
// selectable down-counter that stops at
// zero, with write load and zero flag
//****************************************

`timescale 1ns/1ps

module mon_counter #(
   parameter int DW = 32
) (
   input  logic                       clk,
   input  logic                       reset,
   input  mon_event_pkg::mon_events_t events,
   input  mon_event_pkg::mon_sel_e    sel,
   input  logic                       load,
   input  logic [DW-1:0]              load_data,
   output logic [DW-1:0]              count,
   output logic                       zero_flag
);

   // selected event for this cycle
   logic event_hit;

   // pick one event bit from the select code
   always_comb begin
      case (sel)
         mon_event_pkg::SEL_CLOCK:        event_hit = 1'b1;
         mon_event_pkg::SEL_RX_RD_ACCESS: event_hit = events.rx_rd_access;
         mon_event_pkg::SEL_RX_RD_WAIT:   event_hit = events.rx_rd_wait;
         mon_event_pkg::SEL_RX_WR_ACCESS: event_hit = events.rx_wr_access;
         mon_event_pkg::SEL_RX_WR_WAIT:   event_hit = events.rx_wr_wait;
         mon_event_pkg::SEL_RX_WB_ACCESS: event_hit = events.rx_wb_access;
         mon_event_pkg::SEL_RX_WB_WAIT:   event_hit = events.rx_wb_wait;
         mon_event_pkg::SEL_TX_RD_ACCESS: event_hit = events.tx_rd_access;
         mon_event_pkg::SEL_TX_RD_WAIT:   event_hit = events.tx_rd_wait;
         mon_event_pkg::SEL_TX_WR_ACCESS: event_hit = events.tx_wr_access;
         mon_event_pkg::SEL_TX_WR_WAIT:   event_hit = events.tx_wr_wait;
         mon_event_pkg::SEL_TX_WB_ACCESS: event_hit = events.tx_wb_access;
         mon_event_pkg::SEL_TX_WB_WAIT:   event_hit = events.tx_wb_wait;
         // SEL_OFF and the two spare codes
         default:                         event_hit = 1'b0;
      endcase
   end

   // flag follows the count register directly
   assign zero_flag = (count == '0);

   // load wins over counting
   // decrement only while nonzero, so it parks at zero
   always_ff @(posedge clk) begin
      if (reset) begin
         count <= '1;
      end else if (load) begin
         count <= load_data;
      end else if (event_hit && !zero_flag) begin
         count <= count - 1'b1;
      end
   end

   // count only moves down between loads
   assert property (@(posedge clk) disable iff (reset)
      !load |=> (count <= $past(count)))
      else $error("mon_counter: count rose without a load");

   // once at zero it stays there until the next load
   assert property (@(posedge clk) disable iff (reset)
      (zero_flag && !load) |=> zero_flag)
      else $error("mon_counter: count left zero without a load");

endmodule

//--- emon/mon_regfile.sv
//****************************************
// link monitor register file
// address decode, config register, load
// strobes and registered readback
//****************************************

`timescale 1ns/1ps

module mon_regfile #(
   parameter int DW   = 32,
   parameter int MONS = 6
) (
   input  logic                    clk,
   input  logic                    reset,
   input  mon_reg_pkg::mi_req_t    mi_req,
   input  logic [DW-1:0]           mi_data_in,
   input  logic [DW-1:0]           counts [MONS],
   output logic [DW-1:0]           mi_data_out,
   output mon_event_pkg::mon_sel_e sel [MONS],
   output logic [MONS-1:0]         load,
   output logic [DW-1:0]           load_data
);

   // request decode
   logic            wr_en;
   logic            rd_en;
   logic            cfg_wr;
   logic [MONS-1:0] mon_hit;

   // config and readback
   logic [DW-1:0]   cfg_reg;
   logic [DW-1:0]   rd_mux;

   // map must cover every counter, and the word must hold all select fields
   if (MONS > mon_reg_pkg::NUM_MON_MAX) begin : g_mons_check
      $error("mon_regfile: MONS exceeds the counters in the register map");
   end
   if (DW < mon_event_pkg::SEL_W * MONS) begin : g_dw_check
      $error("mon_regfile: DW too narrow for the select fields");
   end

   assign wr_en  = mi_req.access & mi_req.write;
   assign rd_en  = mi_req.access & ~mi_req.write;
   assign cfg_wr = wr_en & (mi_req.addr == mon_reg_pkg::MON_CFG);

   // config write data also serves as counter load data
   assign load_data = mi_data_in;

   // per-counter address match, load strobe and select slice
   for (genvar i = 0; i < MONS; i++) begin : g_mon
      assign mon_hit[i] = (mi_req.addr == mon_reg_pkg::MON_ADDR[i]);
      assign load[i]    = wr_en & mon_hit[i];
      // counter i owns bits 4i+3 down to 4i
      assign sel[i] = mon_event_pkg::mon_sel_e'(
         cfg_reg[mon_event_pkg::SEL_W*i +: mon_event_pkg::SEL_W]);
   end

   // cleared at reset so every counter starts off
   // new selects apply from the edge after the write
   always_ff @(posedge clk) begin
      if (reset) begin
         cfg_reg <= '0;
      end else if (cfg_wr) begin
         cfg_reg <= mi_data_in;
      end
   end

   // or of and-masked counts
   // no hit means zero, which covers unmapped reads and MON_CFG
   always_comb begin
      rd_mux = '0;
      for (int j = 0; j < MONS; j++) begin
         rd_mux = rd_mux | ({DW{mon_hit[j]}} & counts[j]);
      end
   end

   // data lands one edge after the read, holds otherwise
   always_ff @(posedge clk) begin
      if (reset) begin
         mi_data_out <= '0;
      end else if (rd_en) begin
         mi_data_out <= rd_mux;
      end
   end

   // at most one counter loads per cycle
   assert property (@(posedge clk) disable iff (reset)
      $onehot0(load))
      else $error("mon_regfile: more than one load strobe");

   // a load needs a write access on the port
   assert property (@(posedge clk) disable iff (reset)
      (load != '0) |-> (mi_req.access && mi_req.write))
      else $error("mon_regfile: load without a write access");

endmodule

//--- hdl/traffic_mon_top.sv
//****************************************
// link traffic monitor top
// fifo events into six down-counters
// behind a register port
//****************************************

`timescale 1ns/1ps

module traffic_mon_top #(
   parameter int DW   = 32,
   parameter int MONS = 6
) (
   input  logic                 clk,
   input  logic                 reset,

   // register port
   input  mon_reg_pkg::mi_req_t mi_req,
   input  logic [DW-1:0]        mi_data_in,
   output logic [DW-1:0]        mi_data_out,

   // receive path fifos
   input  logic                 erx_rdfifo_access,
   input  logic                 erx_rdfifo_wait,
   input  logic                 erx_wrfifo_access,
   input  logic                 erx_wrfifo_wait,
   input  logic                 erx_wbfifo_access,
   input  logic                 erx_wbfifo_wait,

   // transmit path fifos
   input  logic                 etx_rdfifo_access,
   input  logic                 etx_rdfifo_wait,
   input  logic                 etx_wrfifo_access,
   input  logic                 etx_wrfifo_wait,
   input  logic                 etx_wbfifo_access,
   input  logic                 etx_wbfifo_wait,

   // one flag per counter, high while it holds zero
   output logic [MONS-1:0]      zero_flag
);

   mon_event_pkg::mon_events_t events;
   mon_event_pkg::mon_sel_e    sel [MONS];
   logic [MONS-1:0]            load;
   logic [DW-1:0]              load_data;
   logic [DW-1:0]              counts [MONS];

   // bundle the fifo levels, shared by all counters
   assign events.rx_rd_access = erx_rdfifo_access;
   assign events.rx_rd_wait   = erx_rdfifo_wait;
   assign events.rx_wr_access = erx_wrfifo_access;
   assign events.rx_wr_wait   = erx_wrfifo_wait;
   assign events.rx_wb_access = erx_wbfifo_access;
   assign events.rx_wb_wait   = erx_wbfifo_wait;
   assign events.tx_rd_access = etx_rdfifo_access;
   assign events.tx_rd_wait   = etx_rdfifo_wait;
   assign events.tx_wr_access = etx_wrfifo_access;
   assign events.tx_wr_wait   = etx_wrfifo_wait;
   assign events.tx_wb_access = etx_wbfifo_access;
   assign events.tx_wb_wait   = etx_wbfifo_wait;

   // decode, config and readback
   mon_regfile #(
      .DW   (DW),
      .MONS (MONS)
   ) u_regfile (
      .clk         (clk),
      .reset       (reset),
      .mi_req      (mi_req),
      .mi_data_in  (mi_data_in),
      .counts      (counts),
      .mi_data_out (mi_data_out),
      .sel         (sel),
      .load        (load),
      .load_data   (load_data)
   );

   // counter i maps to register MON_ADDR[i]
   for (genvar i = 0; i < MONS; i++) begin : g_mon
      mon_counter #(
         .DW (DW)
      ) u_counter (
         .clk       (clk),
         .reset     (reset),
         .events    (events),
         .sel       (sel[i]),
         .load      (load[i]),
         .load_data (load_data),
         .count     (counts[i]),
         .zero_flag (zero_flag[i])
      );
   end

endmodule

//--- tb.f
common/mon_reg_pkg.sv
common/mon_event_pkg.sv
emon/mon_counter.sv
emon/mon_regfile.sv
hdl/traffic_mon_top.sv
tests/tb_traffic_mon.sv

//--- tests/tb_traffic_mon.sv
//****************************************
// link traffic monitor testbench
// table of register steps and fifo events
// checked against a counter model
//****************************************

`timescale 1ns/1ps

module tb_traffic_mon;

   localparam int DW = 32;
   localparam int MONS = 6;

   // bit 31 of the data column asks for random events
   localparam logic [31:0] RAND_EV = 32'h8000_0000;

   typedef enum logic [2:0] {
      WRITE_CFG,
      WRITE_COUNTER,
      RUN_EVENTS,
      READ_COUNTER,
      CHECK_FLAGS
   } step_e;

   // one table row
   typedef struct packed {
      step_e       kind;
      logic [5:0]  addr;
      logic [31:0] data;
      logic [15:0] cycles;
      logic [31:0] expected;
      logic        use_model;
   } step_t;

   logic                       clk;
   logic                       reset;
   mon_reg_pkg::mi_req_t       mi_req;
   logic [DW-1:0]              mi_data_in;
   logic [DW-1:0]              mi_data_out;
   mon_event_pkg::mon_events_t ev;
   logic [MONS-1:0]            zero_flag;

   // model state
   logic [DW-1:0] model_cnt [MONS];
   logic [DW-1:0] model_cfg;
   logic [DW-1:0] model_rd;

   step_t steps [$];

   traffic_mon_top #(
      .DW   (DW),
      .MONS (MONS)
   ) dut (
      .clk               (clk),
      .reset             (reset),
      .mi_req            (mi_req),
      .mi_data_in        (mi_data_in),
      .mi_data_out       (mi_data_out),
      .erx_rdfifo_access (ev.rx_rd_access),
      .erx_rdfifo_wait   (ev.rx_rd_wait),
      .erx_wrfifo_access (ev.rx_wr_access),
      .erx_wrfifo_wait   (ev.rx_wr_wait),
      .erx_wbfifo_access (ev.rx_wb_access),
      .erx_wbfifo_wait   (ev.rx_wb_wait),
      .etx_rdfifo_access (ev.tx_rd_access),
      .etx_rdfifo_wait   (ev.tx_rd_wait),
      .etx_wrfifo_access (ev.tx_wr_access),
      .etx_wrfifo_wait   (ev.tx_wr_wait),
      .etx_wbfifo_access (ev.tx_wb_access),
      .etx_wbfifo_wait   (ev.tx_wb_wait),
      .zero_flag         (zero_flag)
   );

   always #10 clk = ~clk;

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         stop_run($sformatf("Mismatch %s: expected %h, got %h", name, expected, actual));
      end
   endtask

   // counter number behind a register address
   // -1 for an unmapped address
   function automatic int counter_index(input logic [5:0] a);
      if (a >= mon_reg_pkg::RX_MON0 && a <= mon_reg_pkg::TX_MON2) begin
         return int'(a) - int'(mon_reg_pkg::RX_MON0);
      end
      return -1;
   endfunction

   // code 1 counts every cycle
   // codes 2..13 walk the fields from the msb
   function automatic logic model_hit(input logic [3:0] s, input logic [11:0] e);
      if (s == 4'd1) begin
         return 1'b1;
      end
      if (s >= 4'd2 && s <= 4'd13) begin
         return e[13 - s];
      end
      return 1'b0;
   endfunction

   function automatic logic [MONS-1:0] model_flags();
      logic [MONS-1:0] f;
      for (int i = 0; i < MONS; i++) begin
         f[i] = (model_cnt[i] == '0);
      end
      return f;
   endfunction

   // one clock with inputs already driven
   // model follows the edge
   task automatic clock_step();
      logic [DW-1:0] next_cnt [MONS];
      logic [DW-1:0] next_cfg;
      logic [DW-1:0] next_rd;
      logic          wr;
      logic          rd;
      int            idx;
      int            i;
      wr = mi_req.access && mi_req.write;
      rd = mi_req.access && !mi_req.write;
      idx = counter_index(mi_req.addr);
      next_cfg = model_cfg;
      next_rd = model_rd;
      if (wr && mi_req.addr == mon_reg_pkg::MON_CFG) begin
         next_cfg = mi_data_in;
      end
      // unmapped and config reads give zero
      if (rd) begin
         next_rd = (idx >= 0) ? model_cnt[idx] : '0;
      end
      for (i = 0; i < MONS; i++) begin
         if (wr && idx == i) begin
            next_cnt[i] = mi_data_in;
         end else if (model_hit(model_cfg[4*i +: 4], ev) && model_cnt[i] != '0) begin
            next_cnt[i] = model_cnt[i] - 1;
         end else begin
            next_cnt[i] = model_cnt[i];
         end
      end
      @(posedge clk);
      model_cfg = next_cfg;
      model_rd = next_rd;
      for (i = 0; i < MONS; i++) begin
         model_cnt[i] = next_cnt[i];
      end
      @(negedge clk);
   endtask

   task automatic add_row(input step_e kind, input logic [5:0] addr, input logic [31:0] data,
                          input int cycles, input logic [31:0] expected, input logic use_model);
      step_t row;
      row.kind = kind;
      row.addr = addr;
      row.data = data;
      row.cycles = cycles[15:0];
      row.expected = expected;
      row.use_model = use_model;
      steps.push_back(row);
   endtask

   task automatic build_table();
      // values after reset and an unmapped read
      add_row(READ_COUNTER, mon_reg_pkg::RX_MON0, 0, 0, 32'hFFFF_FFFF, 0);
      add_row(READ_COUNTER, mon_reg_pkg::TX_MON2, 0, 0, 32'hFFFF_FFFF, 0);
      add_row(READ_COUNTER, mon_reg_pkg::RX_MON1, 0, 0, 0, 1);
      add_row(READ_COUNTER, mon_reg_pkg::TX_MON1, 0, 0, 0, 1);
      add_row(CHECK_FLAGS, 0, 0, 0, 0, 0);
      add_row(READ_COUNTER, 6'h3F, 0, 0, 0, 0);
      // load and hold with every counter off
      add_row(WRITE_COUNTER, mon_reg_pkg::RX_MON1, 32'h1234_5678, 0, 0, 0);
      add_row(READ_COUNTER, mon_reg_pkg::RX_MON1, 0, 0, 32'h1234_5678, 0);
      add_row(RUN_EVENTS, 0, RAND_EV, 40, 0, 0);
      add_row(READ_COUNTER, mon_reg_pkg::RX_MON1, 0, 0, 32'h1234_5678, 0);
      // clock select runs 1000 down by 25
      add_row(WRITE_CFG, mon_reg_pkg::MON_CFG, 32'h0000_0001, 0, 0, 0);
      add_row(WRITE_COUNTER, mon_reg_pkg::RX_MON0, 32'd1000, 0, 0, 0);
      add_row(RUN_EVENTS, 0, 32'h0, 25, 0, 0);
      add_row(READ_COUNTER, mon_reg_pkg::RX_MON0, 0, 0, 32'd975, 0);
      // a different fifo event per counter
      add_row(WRITE_CFG, mon_reg_pkg::MON_CFG, 32'h00DA_9652, 0, 0, 0);
      for (int i = 0; i < MONS; i++) begin
         add_row(WRITE_COUNTER, 6'(mon_reg_pkg::RX_MON0 + i), 32'h100 * (i + 1), 0, 0, 0);
      end
      add_row(RUN_EVENTS, 0, RAND_EV, 60, 0, 0);
      // tx_wb_wait alone moves only counter 5
      add_row(RUN_EVENTS, 0, 32'h0000_0001, 10, 0, 0);
      for (int i = 0; i < MONS; i++) begin
         add_row(READ_COUNTER, 6'(mon_reg_pkg::RX_MON0 + i), 0, 0, 0, 1);
      end
      // config register is not readable
      add_row(READ_COUNTER, mon_reg_pkg::MON_CFG, 0, 0, 0, 0);
      // run down to zero and park there
      add_row(WRITE_CFG, mon_reg_pkg::MON_CFG, 32'h0000_1000, 0, 0, 0);
      add_row(WRITE_COUNTER, mon_reg_pkg::TX_MON0, 32'd5, 0, 0, 0);
      add_row(CHECK_FLAGS, 0, 0, 20, 32'h08, 0);
      add_row(RUN_EVENTS, 0, 32'h0, 4, 0, 0);
      add_row(READ_COUNTER, mon_reg_pkg::TX_MON0, 0, 0, 0, 0);
      add_row(CHECK_FLAGS, 0, 0, 0, 32'h08, 0);
      add_row(WRITE_COUNTER, mon_reg_pkg::TX_MON0, 32'd3, 0, 0, 0);
      add_row(CHECK_FLAGS, 0, 0, 0, 32'h00, 0);
      // spare codes hold the count
      // load beats the clock select
      add_row(WRITE_CFG, mon_reg_pkg::MON_CFG, 32'h0000_01FE, 0, 0, 0);
      add_row(WRITE_COUNTER, mon_reg_pkg::RX_MON0, 32'h0000_AAAA, 0, 0, 0);
      add_row(WRITE_COUNTER, mon_reg_pkg::RX_MON1, 32'h0000_5555, 0, 0, 0);
      add_row(RUN_EVENTS, 0, RAND_EV, 30, 0, 0);
      add_row(READ_COUNTER, mon_reg_pkg::RX_MON0, 0, 0, 32'h0000_AAAA, 0);
      add_row(READ_COUNTER, mon_reg_pkg::RX_MON1, 0, 0, 32'h0000_5555, 0);
      add_row(WRITE_COUNTER, mon_reg_pkg::RX_MON2, 32'h0000_0077, 0, 0, 0);
      add_row(READ_COUNTER, mon_reg_pkg::RX_MON2, 0, 0, 32'h0000_0077, 0);
      add_row(CHECK_FLAGS, 0, 0, 0, 0, 1);
   endtask

   task automatic do_write(input logic [5:0] addr, input logic [31:0] data);
      mi_req.access = 1'b1;
      mi_req.write = 1'b1;
      mi_req.addr = addr;
      mi_data_in = data;
      clock_step();
      mi_req = '0;
      mi_data_in = '0;
   endtask

   task automatic do_read(input step_t row);
      logic [31:0] expected;
      mi_req.access = 1'b1;
      mi_req.write = 1'b0;
      mi_req.addr = row.addr;
      // nothing new before the edge
      check_value("mi_data_out before read edge", mi_data_out, model_rd);
      clock_step();
      mi_req = '0;
      expected = row.use_model ? model_rd : row.expected;
      check_value($sformatf("mi_data_out addr %h", row.addr), mi_data_out, expected);
   endtask

   task automatic run_events(input step_t row);
      logic [31:0] rnd;
      int          n;
      for (n = 0; n < row.cycles; n++) begin
         rnd = $urandom;
         ev = (row.data & RAND_EV) ? rnd[11:0] : row.data[11:0];
         clock_step();
      end
      ev = '0;
   endtask

   // polls up to cycles clocks for the expected flags
   task automatic check_flags(input step_t row);
      logic [MONS-1:0] expected;
      int              n;
      expected = row.use_model ? model_flags() : row.expected[MONS-1:0];
      n = 0;
      while (n < row.cycles && zero_flag !== expected) begin
         clock_step();
         n++;
      end
      if (row.cycles != 0 && zero_flag !== expected) begin
         stop_run($sformatf("timed out after %0d cycles waiting for zero_flag", n));
      end
      check_value("zero_flag", zero_flag, expected);
      check_value("zero_flag vs model", zero_flag, model_flags());
   endtask

   initial begin
      int k;
      void'($urandom(32'hacbfbe44));
      clk = 1'b0;
      reset = 1'b1;
      mi_req = '0;
      mi_data_in = '0;
      ev = '0;
      model_cfg = '0;
      model_rd = '0;
      for (k = 0; k < MONS; k++) begin
         model_cnt[k] = '1;
      end
      build_table();

      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      for (k = 0; k < steps.size(); k++) begin
         case (steps[k].kind)
            WRITE_CFG,
            WRITE_COUNTER: do_write(steps[k].addr, steps[k].data);
            RUN_EVENTS:    run_events(steps[k]);
            READ_COUNTER:  do_read(steps[k]);
            CHECK_FLAGS:   check_flags(steps[k]);
            default:       stop_run($sformatf("unknown step kind in row %0d", k));
         endcase
      end

      $display("%0d table rows applied", steps.size());
      $display("*** PASSED ***");
      $finish;
   end

endmodule
